// ==== verilog/tcb_mem_pkg.sv ====
// shared bus widths and the request and lane structs, imported by the memory RTL and its bench
package tcb_mem_pkg;

////////////////////////////////////////
// bus geometry
////////////////////////////////////////

  // byte address width
  localparam int unsigned ABW = 12;
  // number of byte lanes on the data bus
  localparam int unsigned BEW = 4;
  // lane width in bits
  localparam int unsigned SLW = 8;

  // byte offset width inside one row
  localparam int unsigned BOW = $clog2(BEW);
  // row address width, the byte address without the lane offset
  localparam int unsigned RAW = ABW - BOW;

////////////////////////////////////////
// bus request
////////////////////////////////////////

  // one transfer as seen on the bus port
  // valid only while the transfer strobe is high
  typedef struct packed {
    // write enable, low for a read
    logic                    wen;
    // byte address, need not be aligned
    logic [ABW-1:0]          adr;
    // byte enables, bit b belongs to bus byte b
    logic [BEW-1:0]          ben;
    // write data, indexed by data lane
    logic [BEW-1:0][SLW-1:0] wdt;
  } tcb_req_t;

////////////////////////////////////////
// per lane request
////////////////////////////////////////

  // what one lane bank needs for a single cycle
  typedef struct packed {
    // read this lane, already gated by the strobe
    logic           ren;
    // write this lane, already gated by the strobe
    logic           wen;
    // row inside the bank, bank wraps it to its depth
    logic [RAW-1:0] row;
    // byte to write
    logic [SLW-1:0] wdt;
  } lane_req_t;

endpackage

// ==== verilog/tcb_mem_req_rotate.sv ====
// combinational mapping of a possibly misaligned bus request onto the lane banks of the memory
module tcb_mem_req_rotate (
  // transfer strobe
  input  logic                                              trn,
  // bus request, valid with the strobe
  input  tcb_mem_pkg::tcb_req_t                             req,
  // one request per lane bank
  output tcb_mem_pkg::lane_req_t [tcb_mem_pkg::BEW-1:0]     lane
);

  import tcb_mem_pkg::*;

////////////////////////////////////////
// address split
////////////////////////////////////////

  // byte offset of bus byte 0 inside its row
  logic [BOW-1:0] off;
  // row holding bus byte 0
  logic [RAW-1:0] base;
  // the row after base, wraps at the top of the row space
  logic [RAW-1:0] next;

  assign off  = req.adr[BOW-1:0];
  assign base = req.adr[ABW-1:BOW];
  assign next = base + RAW'(1);

////////////////////////////////////////
// lane mapping
////////////////////////////////////////

  // bus byte b lands on lane (adr+b) mod BEW
  // so lane l serves bus byte (l-adr) mod BEW
  always_comb begin
    // bus byte served by the current lane
    logic [BOW-1:0] sel;
    // current lane enabled by its bus byte
    logic           ena;
    sel = '0;
    ena = 1'b0;
    for (int unsigned l = 0; l < BEW; l++) begin
      // subtraction wraps in BOW bits, which is the modulo
      sel = BOW'(l) - off;
      ena = req.ben[sel];
      // lanes below the offset hold bytes past the row boundary
      if (BOW'(l) < off) begin
        lane[l].row = next;
      end else begin
        lane[l].row = base;
      end
      // write data already sits on its lane
      lane[l].wdt = req.wdt[l];
      // strobe gates both enables
      lane[l].ren = trn & ~req.wen & ena;
      lane[l].wen = trn &  req.wen & ena;
    end
  end

endmodule

// ==== verilog/tcb_mem_lane.sv ====
// one byte wide synchronous memory bank, instantiated once per data lane by the memory top
module tcb_mem_lane #(
  // number of rows, a power of two
  parameter int unsigned DEPTH = 64
)(
  // clock
  input  logic                        tcb,
  // lane request from the rotator
  input  tcb_mem_pkg::lane_req_t      req,
  // registered read byte
  output logic [tcb_mem_pkg::SLW-1:0] rdt
);

  import tcb_mem_pkg::*;

  // row index width inside the bank
  localparam int unsigned IDW = $clog2(DEPTH);

////////////////////////////////////////
// storage
////////////////////////////////////////

  // byte array for this lane
  logic [SLW-1:0] mem [0:DEPTH-1];

  // row wrapped to the bank depth
  // upper row bits drop out since DEPTH is a power of two
  logic [IDW-1:0] idx;

  assign idx = req.row[IDW-1:0];

////////////////////////////////////////
// access
////////////////////////////////////////

  // write on the edge of the strobe
  always_ff @(posedge tcb) begin
    if (req.wen) begin
      mem[idx] <= req.wdt;
    end
  end

  // read byte registered on the strobe edge
  // output holds while no read hits this lane
  always_ff @(posedge tcb) begin
    if (req.ren) begin
      rdt <= mem[idx];
    end
  end

endmodule

// ==== verilog/tcb_mem_rsp_pipe.sv ====
// read response pipeline of the memory, adds the latency beyond the bank read cycle per lane
module tcb_mem_rsp_pipe #(
  // total read latency, 1 or more
  parameter int unsigned DLY = 1
)(
  // clock
  input  logic                                              tcb,
  // synchronous reset, active high
  input  logic                                              reset,
  // per lane read enables, same cycle as the strobe
  input  logic [tcb_mem_pkg::BEW-1:0]                       ren,
  // bank read bytes, one cycle after the strobe
  input  logic [tcb_mem_pkg::BEW-1:0][tcb_mem_pkg::SLW-1:0] lane_rdt,
  // bus read data
  output logic [tcb_mem_pkg::BEW-1:0][tcb_mem_pkg::SLW-1:0] rdt
);

  import tcb_mem_pkg::*;

  generate
  if (DLY == 1) begin : direct

    // bank register is the whole latency
    // banks already hold bytes that were not read
    assign rdt = lane_rdt;

  end else begin : stages

////////////////////////////////////////
// enable and data stages
////////////////////////////////////////

    // ren delayed by d cycles
    logic [BEW-1:0]          ena [1:DLY-1];
    // read data after stage d
    logic [BEW-1:0][SLW-1:0] dat [1:DLY-1];

    always_ff @(posedge tcb) begin
      if (reset) begin
        for (int unsigned d = 1; d < DLY; d++) begin
          ena[d] <= '0;
          dat[d] <= '0;
        end
      end else begin
        // first stage lines up with the bank output
        ena[1] <= ren;
        for (int unsigned l = 0; l < BEW; l++) begin
          if (ena[1][l]) begin
            dat[1][l] <= lane_rdt[l];
          end
        end
        // later stages, absent when DLY is 2
        for (int unsigned d = 2; d < DLY; d++) begin
          ena[d] <= ena[d-1];
          for (int unsigned l = 0; l < BEW; l++) begin
            // lanes not read keep their byte
            if (ena[d][l]) begin
              dat[d][l] <= dat[d-1][l];
            end
          end
        end
      end
    end

    // last stage drives the bus
    assign rdt = dat[DLY-1];

  end
  endgenerate

endmodule

// ==== verilog/tcb_mem.sv ====
// byte addressed memory on one tightly coupled bus port, the top level instantiated by the bench
module tcb_mem #(
  // memory size in bytes, a power of two and a multiple of BEW
  parameter int unsigned SZ  = 256,
  // read latency in cycles, 1 or more
  parameter int unsigned DLY = 1
)(
  // clock
  input  logic                                              tcb,
  // synchronous reset, active high
  input  logic                                              reset,
  // one cycle transfer strobe
  input  logic                                              trn,
  // request, valid with the strobe
  input  tcb_mem_pkg::tcb_req_t                             req,
  // read data, DLY cycles after a read strobe
  output logic [tcb_mem_pkg::BEW-1:0][tcb_mem_pkg::SLW-1:0] rdt
);

  import tcb_mem_pkg::*;

////////////////////////////////////////
// internal wires
////////////////////////////////////////

  // rotated request per lane
  lane_req_t [BEW-1:0]          lane_req;
  // read enable per lane
  logic      [BEW-1:0]          lane_ren;
  // bank read byte per lane
  logic      [BEW-1:0][SLW-1:0] lane_rdt;

  // request rotator, all address arithmetic lives here
  tcb_mem_req_rotate rotate (
    .trn  (trn),
    .req  (req),
    .lane (lane_req)
  );

  // one bank per data lane
  generate
  for (genvar l = 0; l < BEW; l++) begin : lane
    tcb_mem_lane #(
      .DEPTH (SZ/BEW)
    ) bank (
      .tcb (tcb),
      .req (lane_req[l]),
      .rdt (lane_rdt[l])
    );
    // read enables travel on with the data
    assign lane_ren[l] = lane_req[l].ren;
  end
  endgenerate

  // response pipeline up to the full latency
  tcb_mem_rsp_pipe #(
    .DLY (DLY)
  ) rsp (
    .tcb      (tcb),
    .reset    (reset),
    .ren      (lane_ren),
    .lane_rdt (lane_rdt),
    .rdt      (rdt)
  );

endmodule

// ==== bench/tcb_mem_chk.sv ====
// bound protocol and response assertions on the memory top ports, attached by the bind below
module tcb_mem_chk #(
  // read latency of the bound memory
  parameter int unsigned DLY = 1
)(
  input  logic                                              tcb,
  input  logic                                              reset,
  input  logic                                              trn,
  input  tcb_mem_pkg::tcb_req_t                             req,
  input  logic [tcb_mem_pkg::BEW-1:0][tcb_mem_pkg::SLW-1:0] rdt
);

  import tcb_mem_pkg::*;

////////////////////////////////////////
// history of reads and reset
////////////////////////////////////////

  // a read that reaches at least one lane
  logic           rd;
  // rd delayed, bit d holds the read d+1 edges back
  logic [DLY-1:0] hist;
  // reset seen on the previous edge
  logic           rst_q;
  // set once the first reset has gone by
  logic           armed = 1'b0;
  // assertion failures so far, read by the bench
  int unsigned    fail_cnt = 0;

  assign rd = trn & ~req.wen & (|req.ben);

  always_ff @(posedge tcb) begin
    rst_q   <= reset;
    hist[0] <= rd;
    for (int unsigned d = 1; d < DLY; d++) begin
      hist[d] <= hist[d-1];
    end
    if (reset) begin
      armed <= 1'b1;
    end
  end

////////////////////////////////////////
// assertions
////////////////////////////////////////

  // no unknown request bits with the strobe
  req_known: assert property (@(posedge tcb) trn |-> !$isunknown(req))
    else begin
      fail_cnt++;
      $error("request holds unknown bits while trn is high");
    end

  // response register cleared by reset
  rst_zero: assert property (@(posedge tcb) rst_q |-> (rdt == '0))
    else begin
      fail_cnt++;
      $error("rdt not zero in the cycle after reset");
    end

  // only a read DLY edges back may move rdt
  // unwritten bytes read back as unknown, so compare all four states
  rdt_hold: assert property (@(posedge tcb)
    (armed && !rst_q && !hist[DLY-1]) |-> (rdt === $past(rdt)))
    else begin
      fail_cnt++;
      $error("rdt changed although no read was due");
    end

endmodule

bind tcb_mem tcb_mem_chk #(
  .DLY (DLY)
) chk (
  .tcb   (tcb),
  .reset (reset),
  .trn   (trn),
  .req   (req),
  .rdt   (rdt)
);

// ==== bench/tcb_mem_monitor.sv ====
// reference byte memory for the bench, predicts the read data image from bus traffic and checks rdt
module tcb_mem_monitor #(
  // memory size in bytes
  parameter int unsigned SZ  = 256,
  // read latency in cycles
  parameter int unsigned DLY = 1
)(
  input  logic                                              tcb,
  input  logic                                              reset,
  input  logic                                              trn,
  input  tcb_mem_pkg::tcb_req_t                             req,
  // table expectation, travels with a read strobe
  input  logic                                              tab_chk,
  input  logic [tcb_mem_pkg::BEW-1:0][tcb_mem_pkg::SLW-1:0] tab_rdt,
  // DUT read data
  input  logic [tcb_mem_pkg::BEW-1:0][tcb_mem_pkg::SLW-1:0] rdt,
  // mismatches seen so far
  output int unsigned                                       errors,
  // reads still in flight
  output int unsigned                                       pending
);

  import tcb_mem_pkg::*;

  // one predicted rdt image
  typedef struct packed {
    int unsigned             due;
    logic [BEW-1:0][SLW-1:0] img;
    logic [BEW-1:0]          vld;
    logic                    chk;
    logic [BEW-1:0][SLW-1:0] tab;
  } pred_t;

////////////////////////////////////////
// model state
////////////////////////////////////////

  logic [SLW-1:0] mem [0:SZ-1];
  // byte written at least once
  bit             written [0:SZ-1];

  pred_t                   fifo [$];
  int unsigned             cycle    = 0;
  int unsigned             err_cnt  = 0;
  int unsigned             pend_cnt = 0;
  bit                      armed    = 1'b0;
  // image currently expected on rdt
  logic [BEW-1:0][SLW-1:0] shown_img;
  logic [BEW-1:0]          shown_vld;
  // image after the latest read strobe
  logic [BEW-1:0][SLW-1:0] last_img;
  logic [BEW-1:0]          last_vld;

  assign errors  = err_cnt;
  assign pending = pend_cnt;

  // memory address of bus byte b, wraps at the memory size
  function automatic int unsigned mem_index(input logic [ABW-1:0] adr, input int unsigned b);
    return (32'(adr) + b) % SZ;
  endfunction

  // compare rdt against the expected image, unknown model bytes skipped
  function automatic void check_shown();
    for (int unsigned l = 0; l < BEW; l++) begin
      if (shown_vld[l] && (rdt[l] !== shown_img[l])) begin
        $display("CHECK FAILED at %0t: rdt lane %0d expected %h got %h",
                 $time, l, shown_img[l], rdt[l]);
        err_cnt++;
      end
    end
  endfunction

  // full word compare against a hand written table value
  function automatic void check_table(input logic [BEW-1:0][SLW-1:0] tab);
    if (rdt !== tab) begin
      $display("CHECK FAILED at %0t: rdt expected %h got %h", $time, tab, rdt);
      err_cnt++;
    end
  endfunction

////////////////////////////////////////
// per edge update
////////////////////////////////////////

  always @(posedge tcb) begin
    pred_t       p;
    int unsigned a;
    int unsigned sel;
    cycle++;
    if (reset) begin
      // reset clears the response image, memory keeps its bytes
      fifo.delete();
      shown_img = '0;
      shown_vld = '1;
      last_img  = '0;
      last_vld  = '1;
      armed     = 1'b1;
    end else if (armed) begin
      // retire reads whose latency has run out
      while (fifo.size() != 0 && fifo[0].due <= cycle) begin
        p = fifo.pop_front();
        shown_img = p.img;
        shown_vld = p.vld;
        if (p.chk) begin
          check_table(p.tab);
        end
      end
      check_shown();
      if (trn && req.wen) begin
        // bus byte b goes to address adr+b on lane (adr+b) mod BEW
        for (int unsigned b = 0; b < BEW; b++) begin
          if (req.ben[b]) begin
            a = mem_index(req.adr, b);
            mem[a]     = req.wdt[a % BEW];
            written[a] = 1'b1;
          end
        end
      end else if (trn) begin
        // lane l carries bus byte (l-adr) mod BEW
        for (int unsigned l = 0; l < BEW; l++) begin
          sel = (l + BEW - (32'(req.adr) % BEW)) % BEW;
          if (req.ben[sel]) begin
            a = mem_index(req.adr, sel);
            last_img[l] = mem[a];
            last_vld[l] = written[a];
          end
        end
        p.due = cycle + DLY;
        p.img = last_img;
        p.vld = last_vld;
        p.chk = tab_chk;
        p.tab = tab_rdt;
        fifo.push_back(p);
      end
    end
    pend_cnt = fifo.size();
  end

endmodule

// ==== bench/tcb_mem_tb.sv ====
// top testbench of the memory, runs a directed table then random traffic and prints the verdict
module tcb_mem_tb;

  import tcb_mem_pkg::*;

  localparam int unsigned SZ        = 256;
  localparam int unsigned DLY       = 2;
  // input drive delay after the rising edge
  localparam int unsigned DRIVE_DLY = 1;
  localparam int unsigned RND_N     = 200;
  localparam int unsigned DRAIN_MAX = 4*DLY + 8;

  // one table entry, request plus expected read image
  typedef struct packed {
    tcb_req_t                req;
    logic                    chk;
    logic [BEW-1:0][SLW-1:0] exp;
  } step_t;

  logic                    tcb;
  logic                    reset;
  logic                    trn;
  tcb_req_t                req;
  logic                    tab_chk;
  logic [BEW-1:0][SLW-1:0] tab_rdt;
  logic [BEW-1:0][SLW-1:0] rdt;
  int unsigned             mon_errors;
  int unsigned             mon_pending;
  int unsigned             bench_errors = 0;
  step_t                   steps [$];

  always #4 tcb = ~tcb;

  tcb_mem #(
    .SZ  (SZ),
    .DLY (DLY)
  ) UUT (
    .tcb   (tcb),
    .reset (reset),
    .trn   (trn),
    .req   (req),
    .rdt   (rdt)
  );

  tcb_mem_monitor #(
    .SZ  (SZ),
    .DLY (DLY)
  ) mon (
    .tcb     (tcb),
    .reset   (reset),
    .trn     (trn),
    .req     (req),
    .tab_chk (tab_chk),
    .tab_rdt (tab_rdt),
    .rdt     (rdt),
    .errors  (mon_errors),
    .pending (mon_pending)
  );

////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////

  // write entry, wdt already sits on its data lanes
  task automatic add_write(input logic [ABW-1:0] adr, input logic [BEW-1:0] ben,
                           input logic [BEW-1:0][SLW-1:0] wdt);
    step_t s;
    s.req = '{wen: 1'b1, adr: adr, ben: ben, wdt: wdt};
    s.chk = 1'b0;
    s.exp = '0;
    steps.push_back(s);
  endtask

  // read entry with the full rdt image expected DLY cycles on
  task automatic add_read(input logic [ABW-1:0] adr, input logic [BEW-1:0] ben,
                          input logic [BEW-1:0][SLW-1:0] exp);
    step_t s;
    s.req = '{wen: 1'b0, adr: adr, ben: ben, wdt: '0};
    s.chk = 1'b1;
    s.exp = exp;
    steps.push_back(s);
  endtask

  task automatic drive_transfer(input tcb_req_t r, input logic chk,
                                input logic [BEW-1:0][SLW-1:0] exp);
    @(posedge tcb);
    #(DRIVE_DLY);
    trn     = 1'b1;
    req     = r;
    tab_chk = chk;
    tab_rdt = exp;
  endtask

  task automatic drive_idle();
    @(posedge tcb);
    #(DRIVE_DLY);
    trn     = 1'b0;
    req     = '0;
    tab_chk = 1'b0;
    tab_rdt = '0;
  endtask

  // wait for the monitor to retire every read in flight
  task automatic wait_drained();
    int unsigned n;
    n = 0;
    while (mon_pending != 0 && n < DRAIN_MAX) begin
      @(posedge tcb);
      #(DRIVE_DLY);
      n++;
    end
    if (mon_pending != 0) begin
      $display("timeout: %0d reads still in flight after %0d cycles", mon_pending, DRAIN_MAX);
      bench_errors++;
    end
  endtask

////////////////////////////////////////
// main sequence
////////////////////////////////////////

  initial begin
    tcb_req_t    r;
    int unsigned chk_fails;
    void'($urandom(32'hd5a6));
    tcb     = 1'b0;
    reset   = 1'b1;
    trn     = 1'b0;
    req     = '0;
    tab_chk = 1'b0;
    tab_rdt = '0;
    repeat (2) @(posedge tcb);
    #(DRIVE_DLY);
    reset = 1'b0;
    drive_idle();

    // aligned word, then misaligned across a row
    add_write(12'h000, 4'hF, 32'h44332211);
    add_read (12'h000, 4'hF, 32'h44332211);
    add_write(12'h005, 4'hF, 32'h77665588);
    add_read (12'h005, 4'hF, 32'h77665588);
    // wrap from the top address to 0
    add_write(12'hFFE, 4'hF, 32'hA3A2A1A0);
    add_read (12'h0FE, 4'hF, 32'hA3A2A1A0);
    // partial enables
    add_write(12'h004, 4'b0001, 32'hDEADBE99);
    add_read (12'h003, 4'hF, 32'h44665599);
    add_write(12'h001, 4'b0110, 32'hC3C2C1C0);
    add_read (12'h000, 4'hF, 32'hC3C2A1A0);
    add_read (12'h006, 4'b0101, 32'hC366A188);
    // write then three reads back to back
    add_write(12'h0FF, 4'hF, 32'hB3B2B1B0);
    add_read (12'h0FF, 4'hF, 32'hB3B2B1B0);
    add_read (12'hEFD, 4'b0010, 32'hB3A2B1B0);
    add_read (12'h005, 4'hF, 32'h77665588);

    foreach (steps[i]) begin
      drive_transfer(steps[i].req, steps[i].chk, steps[i].exp);
    end
    drive_idle();
    wait_drained();

    // random mix, mostly low addresses with some near the top
    for (int unsigned i = 0; i < RND_N; i++) begin
      r.wen = 1'($urandom_range(0, 1));
      if ($urandom_range(0, 3) == 0) begin
        r.adr = ABW'(12'hFF0 + $urandom_range(0, 15));
      end else begin
        r.adr = ABW'($urandom_range(0, 47));
      end
      r.ben = BEW'($urandom_range(0, 15));
      r.wdt = $urandom();
      if ($urandom_range(0, 4) == 0) begin
        drive_idle();
      end
      drive_transfer(r, 1'b0, '0);
    end
    drive_idle();
    wait_drained();
    drive_idle();

    chk_fails = UUT.chk.fail_cnt;
    $display("closing report: %0d monitor errors, %0d assertion failures, %0d bench errors",
             mon_errors, chk_fails, bench_errors);
    if (mon_errors == 0 && chk_fails == 0 && bench_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
verilog/tcb_mem_pkg.sv
verilog/tcb_mem_req_rotate.sv
verilog/tcb_mem_lane.sv
verilog/tcb_mem_rsp_pipe.sv
verilog/tcb_mem.sv
bench/tcb_mem_chk.sv
bench/tcb_mem_monitor.sv
bench/tcb_mem_tb.sv

// ==== Makefile ====
# Verilator flow for the tcb memory: lint, simulate, clean
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tcb_mem_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS      ?= Everything OK
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# build, run into the log, then decide by the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
